// ==== bus_pkg.sv ====
// lite-bus widths, data, strobe and response types
`default_nettype none

package bus_pkg;

   ////////////////////////////////////////
   // widths

   localparam int BUS_ADDR_W = 32;
   localparam int BUS_DATA_W = 64;
   localparam int BUS_STRB_W = BUS_DATA_W / 8;   // one strobe per byte

   ////////////////////////////////////////
   // payload types

   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [BUS_DATA_W-1:0] bus_data_t;
   typedef logic [BUS_STRB_W-1:0] bus_strb_t;

   // response code, same values as the lite bus
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_DECERR = 2'b11   // nobody claims the address
   } bus_resp_e;

endpackage

`default_nettype wire

// ==== io_map_pkg.sv ====
// device count, memory sizes, base/mask map and the memory address union
`default_nettype none

package io_map_pkg;

   import bus_pkg::*;

   ////////////////////////////////////////
   // devices and memory geometry

   localparam int NUM_DEVICE     = 2;    // 0 boot memory, 1 video memory
   localparam int LINE_W         = 128;  // memory line, two bus words
   localparam int OFFSET_BITS    = 3;    // byte within a bus word
   localparam int LANE_BITS      = 1;    // bus word within a line
   localparam int BOOT_MEM_BITS  = 16;   // 64 KiB
   localparam int VIDEO_MEM_BITS = 18;   // 256 KiB
   localparam int MAX_MEM_BITS   =
      (BOOT_MEM_BITS > VIDEO_MEM_BITS) ? BOOT_MEM_BITS : VIDEO_MEM_BITS;

   ////////////////////////////////////////
   // address map

   localparam bus_addr_t BOOT_BASE  = 32'h4000_0000;
   localparam bus_addr_t BOOT_MASK  = bus_addr_t'((1 << BOOT_MEM_BITS) - 1);
   localparam bus_addr_t VIDEO_BASE = 32'h4010_0000;
   localparam bus_addr_t VIDEO_MASK = bus_addr_t'((1 << VIDEO_MEM_BITS) - 1);

   localparam bus_addr_t dev_base [NUM_DEVICE] = '{BOOT_BASE, VIDEO_BASE};
   localparam bus_addr_t dev_mask [NUM_DEVICE] = '{BOOT_MASK, VIDEO_MASK};

   ////////////////////////////////////////
   // memory byte address

   typedef struct packed {
      logic [MAX_MEM_BITS-LANE_BITS-OFFSET_BITS-1:0] line;
      logic [LANE_BITS-1:0]                          lane;
      logic [OFFSET_BITS-1:0]                        offset;
   } mem_addr_s;

   // raw byte address or split line/lane/offset view
   typedef union packed {
      logic [MAX_MEM_BITS-1:0] raw;
      mem_addr_s               f;
   } mem_addr_u;

endpackage

`default_nettype wire

// ==== lite_if.sv ====
// lite_if request/response interface and ram_port_if memory port interface
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////
// lite bus, one transaction at a time

interface lite_if import bus_pkg::*; ();

   logic      req_valid;
   logic      req_ready;
   logic      req_write;
   bus_addr_t req_addr;
   bus_data_t req_wdata;
   bus_strb_t req_wstrb;

   logic      rsp_valid;
   logic      rsp_ready;
   bus_data_t rsp_rdata;
   bus_resp_e rsp_resp;

   modport master (
      output req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
      input  req_ready, rsp_valid, rsp_rdata, rsp_resp
   );

   modport slave (
      input  req_valid, req_write, req_addr, req_wdata, req_wstrb, rsp_ready,
      output req_ready, rsp_valid, rsp_rdata, rsp_resp
   );

endinterface

////////////////////////////////////////
// memory port, read data one cycle after en

interface ram_port_if import bus_pkg::*, io_map_pkg::*; ();

   logic      en;
   bus_strb_t we;      // byte write enables
   mem_addr_u addr;
   bus_data_t wdata;
   bus_data_t rdata;

   modport ctrl (
      output en, we, addr, wdata,
      input  rdata
   );

   modport mem (
      input  en, we, addr, wdata,
      output rdata
   );

endinterface

`default_nettype wire

// ==== io_addr_decode.sv ====
// address decoder routing one lite transaction to a device or a decode error
`timescale 1ns/100ps
`default_nettype none

module io_addr_decode import bus_pkg::*, io_map_pkg::*; (
   input  logic      ram_clk,
   input  logic      rst_n_i,
   input  logic      req_valid_i,
   output logic      req_ready_o,
   input  logic      req_write_i,
   input  bus_addr_t req_addr_i,
   input  bus_data_t req_wdata_i,
   input  bus_strb_t req_wstrb_i,
   output logic      rsp_valid_o,
   input  logic      rsp_ready_i,
   output bus_data_t rsp_rdata_o,
   output bus_resp_e rsp_resp_o,
   lite_if.master    dev [NUM_DEVICE]
);

   typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_WAIT, ST_RESP} dec_state_e;

   dec_state_e              state_q;
   logic [NUM_DEVICE-1:0]   hit, sel_q;
   logic [NUM_DEVICE-1:0]   dev_req_ready, dev_rsp_valid;
   bus_data_t               dev_rsp_rdata [NUM_DEVICE];
   bus_resp_e               dev_rsp_resp [NUM_DEVICE];
   logic                    sel_req_ready, sel_rsp_valid;
   bus_data_t               sel_rdata;
   bus_resp_e               sel_resp;
   logic                    write_q;
   bus_addr_t               addr_q;
   bus_data_t               wdata_q;
   bus_strb_t               wstrb_q;
   bus_data_t               rsp_rdata_q;
   bus_resp_e               rsp_resp_q;

   ////////////////////////////////////////
   // per device decode and wiring

   for (genvar i = 0; i < NUM_DEVICE; i++) begin : g_dev
      assign hit[i] = (req_addr_i & ~dev_mask[i]) == dev_base[i];

      assign dev[i].req_valid = (state_q == ST_FWD) && sel_q[i];
      assign dev[i].req_write = write_q;
      assign dev[i].req_addr  = addr_q;
      assign dev[i].req_wdata = wdata_q;
      assign dev[i].req_wstrb = wstrb_q;
      assign dev[i].rsp_ready = (state_q == ST_WAIT) && sel_q[i];

      assign dev_req_ready[i] = dev[i].req_ready;
      assign dev_rsp_valid[i] = dev[i].rsp_valid;
      assign dev_rsp_rdata[i] = dev[i].rsp_rdata;
      assign dev_rsp_resp[i]  = dev[i].rsp_resp;
   end

   assign sel_req_ready = |(dev_req_ready & sel_q);
   assign sel_rsp_valid = |(dev_rsp_valid & sel_q);

   always_comb begin
      sel_rdata = '0;
      sel_resp  = RESP_OKAY;
      for (int i = 0; i < NUM_DEVICE; i++) begin
         if (sel_q[i]) begin
            sel_rdata = dev_rsp_rdata[i];
            sel_resp  = dev_rsp_resp[i];
         end
      end
   end

   ////////////////////////////////////////
   // transaction FSM

   always_ff @(posedge ram_clk) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         sel_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: if (req_valid_i) begin
               sel_q   <= hit;
               state_q <= (|hit) ? ST_FWD : ST_RESP;   // miss answers at once
            end
            ST_FWD:  if (sel_req_ready) state_q <= ST_WAIT;
            ST_WAIT: if (sel_rsp_valid) state_q <= ST_RESP;
            ST_RESP: if (rsp_ready_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge ram_clk) begin
      if (state_q == ST_IDLE && req_valid_i) begin
         write_q     <= req_write_i;
         addr_q      <= req_addr_i;
         wdata_q     <= req_wdata_i;
         wstrb_q     <= req_wstrb_i;
         rsp_rdata_q <= '0;             // decode error default
         rsp_resp_q  <= RESP_DECERR;
      end
      if (state_q == ST_WAIT && sel_rsp_valid) begin
         rsp_rdata_q <= sel_rdata;
         rsp_resp_q  <= sel_resp;
      end
   end

   assign req_ready_o = (state_q == ST_IDLE);
   assign rsp_valid_o = (state_q == ST_RESP);
   assign rsp_rdata_o = rsp_rdata_q;
   assign rsp_resp_o  = rsp_resp_q;

endmodule

`default_nettype wire

// ==== lite_bram_ctrl.sv ====
// lite bus to memory port controller for one memory
`timescale 1ns/100ps
`default_nettype none

module lite_bram_ctrl import bus_pkg::*, io_map_pkg::*; #(
   parameter int MEM_BITS = BOOT_MEM_BITS
) (
   input  logic   ram_clk,
   input  logic   rst_n_i,
   lite_if.slave  bus,
   ram_port_if.ctrl ram
);

   logic      rsp_valid_q;
   logic      first_q;       // first response cycle, memory data live
   logic      write_q;
   bus_data_t rdata_q;
   bus_data_t rd_data;
   mem_addr_u addr_u;
   logic      accept;

   ////////////////////////////////////////
   // request side

   assign accept = bus.req_valid && bus.req_ready;

   assign addr_u.raw = MAX_MEM_BITS'(bus.req_addr[MEM_BITS-1:0]);

   assign ram.en    = accept;
   assign ram.we    = bus.req_write ? bus.req_wstrb : '0;
   assign ram.addr  = addr_u;
   assign ram.wdata = bus.req_wdata;

   assign bus.req_ready = !rsp_valid_q;   // back-pressure while a response waits

   ////////////////////////////////////////
   // response side

   always_ff @(posedge ram_clk) begin
      if (!rst_n_i) begin
         rsp_valid_q <= 1'b0;
         first_q     <= 1'b0;
      end else begin
         first_q <= accept;
         if (accept)
            rsp_valid_q <= 1'b1;
         else if (bus.rsp_ready)
            rsp_valid_q <= 1'b0;
      end
   end

   assign rd_data = write_q ? '0 : ram.rdata;   // writes return zero

   always_ff @(posedge ram_clk) begin
      if (accept)
         write_q <= bus.req_write;
      if (first_q)
         rdata_q <= rd_data;
   end

   assign bus.rsp_valid = rsp_valid_q;
   assign bus.rsp_rdata = first_q ? rd_data : rdata_q;
   assign bus.rsp_resp  = RESP_OKAY;

endmodule

`default_nettype wire

// ==== bram_lane_mem.sv ====
// 128-bit line memory with lane steering of strobes, write and read data
`timescale 1ns/100ps
`default_nettype none

module bram_lane_mem import bus_pkg::*, io_map_pkg::*; #(
   parameter int MEM_BITS = BOOT_MEM_BITS
) (
   input  logic    ram_clk,
   ram_port_if.mem ram
);

   localparam int LINES = 2 ** MEM_BITS / (LINE_W / 8);
   localparam int IDX_W = MEM_BITS - LANE_BITS - OFFSET_BITS;
   localparam int LANES = LINE_W / BUS_DATA_W;

   logic [LINE_W-1:0]    mem_q [LINES];
   logic [IDX_W-1:0]     line_idx, line_q;
   logic [LANE_BITS-1:0] lane, lane_q;
   logic [LINE_W/8-1:0]  we_full;
   logic [LINE_W-1:0]    wdata_full;
   logic [LINE_W-1:0]    rline;

   ////////////////////////////////////////
   // lane steering

   assign line_idx = ram.addr.f.line[IDX_W-1:0];
   assign lane     = ram.addr.f.lane;

   assign we_full    = (LINE_W/8)'(ram.we) << (lane * BUS_STRB_W);
   assign wdata_full = {LANES{ram.wdata}};   // every lane sees the word

   always_ff @(posedge ram_clk) begin
      if (ram.en) begin
         line_q <= line_idx;
         lane_q <= lane;
         for (int b = 0; b < LINE_W / 8; b++) begin
            if (we_full[b])
               mem_q[line_idx][b*8 +: 8] <= wdata_full[b*8 +: 8];
         end
      end
   end

   // read from the stored line and lane
   assign rline     = mem_q[line_q];
   assign ram.rdata = rline[lane_q*BUS_DATA_W +: BUS_DATA_W];

endmodule

`default_nettype wire

// ==== io_subsys_top.sv ====
// RTL top level with address decoder and two controller/memory pairs
`timescale 1ns/100ps
`default_nettype none

module io_subsys_top import bus_pkg::*, io_map_pkg::*; (
   input  logic      ram_clk,
   input  logic      rst_n_i,
   input  logic      req_valid_i,
   output logic      req_ready_o,
   input  logic      req_write_i,
   input  bus_addr_t req_addr_i,
   input  bus_data_t req_wdata_i,
   input  bus_strb_t req_wstrb_i,
   output logic      rsp_valid_o,
   input  logic      rsp_ready_i,
   output bus_data_t rsp_rdata_o,
   output bus_resp_e rsp_resp_o
);

   lite_if     dev_bus [NUM_DEVICE] ();
   ram_port_if ram_port [NUM_DEVICE] ();

   ////////////////////////////////////////
   // address decoder

   io_addr_decode io_addr_decode_i (
      .ram_clk     ( ram_clk     ),
      .rst_n_i     ( rst_n_i     ),
      .req_valid_i ( req_valid_i ),
      .req_ready_o ( req_ready_o ),
      .req_write_i ( req_write_i ),
      .req_addr_i  ( req_addr_i  ),
      .req_wdata_i ( req_wdata_i ),
      .req_wstrb_i ( req_wstrb_i ),
      .rsp_valid_o ( rsp_valid_o ),
      .rsp_ready_i ( rsp_ready_i ),
      .rsp_rdata_o ( rsp_rdata_o ),
      .rsp_resp_o  ( rsp_resp_o  ),
      .dev         ( dev_bus     )
   );

   ////////////////////////////////////////
   // memories, device 0 boot, device 1 video

   for (genvar d = 0; d < NUM_DEVICE; d++) begin : g_mem
      localparam int MEM_BITS = (d == 0) ? BOOT_MEM_BITS : VIDEO_MEM_BITS;

      lite_bram_ctrl #(
         .MEM_BITS ( MEM_BITS )
      ) lite_bram_ctrl_i (
         .ram_clk ( ram_clk     ),
         .rst_n_i ( rst_n_i     ),
         .bus     ( dev_bus[d]  ),
         .ram     ( ram_port[d] )
      );

      bram_lane_mem #(
         .MEM_BITS ( MEM_BITS )
      ) bram_lane_mem_i (
         .ram_clk ( ram_clk     ),
         .ram     ( ram_port[d] )
      );
   end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);   // low for RST_CYCLES edges
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== tb_io_subsys.sv ====
// testbench for the io subsystem with random stimulus and a byte memory model
`timescale 1ns/100ps
`default_nettype none

module tb_io_subsys import bus_pkg::*, io_map_pkg::*; ();

   localparam int WAIT_LIMIT  = 50;   // cycles per wait
   localparam int NUM_RANDOM  = 400;
   localparam int MODEL_BYTES = 2 ** MAX_MEM_BITS;

   logic      ram_clk, rst_n;
   logic      req_valid_i, req_ready_o, req_write_i, rsp_valid_o, rsp_ready_i;
   bus_addr_t req_addr_i;
   bus_data_t req_wdata_i, rsp_rdata_o;
   bus_strb_t req_wstrb_i;
   bus_resp_e rsp_resp_o;

   logic [7:0]  model_mem [NUM_DEVICE][MODEL_BYTES];
   bit          model_wr  [NUM_DEVICE][MODEL_BYTES];   // byte written once
   logic [31:0] rng_state;
   int          rdata_errs, resp_errs, flag_errs, timeout_errs;
   logic        aborted;

   tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(10)) tb_clk_gen_i (
      .clk_o ( ram_clk ), .rst_n_o ( rst_n )
   );

   io_subsys_top io_subsys_top_i (
      .ram_clk     ( ram_clk     ), .rst_n_i     ( rst_n       ),
      .req_valid_i ( req_valid_i ), .req_ready_o ( req_ready_o ),
      .req_write_i ( req_write_i ), .req_addr_i  ( req_addr_i  ),
      .req_wdata_i ( req_wdata_i ), .req_wstrb_i ( req_wstrb_i ),
      .rsp_valid_o ( rsp_valid_o ), .rsp_ready_i ( rsp_ready_i ),
      .rsp_rdata_o ( rsp_rdata_o ), .rsp_resp_o  ( rsp_resp_o  )
   );

   ////////////////////////////////////////
   // random numbers and checks

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      return s ^ (s << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   task automatic check_rdata(input string name, input bus_data_t got, input bus_data_t exp,
                              input bus_strb_t mask);
      bus_data_t bits;
      for (int b = 0; b < BUS_STRB_W; b++)
         bits[b*8 +: 8] = {8{mask[b]}};
      if ((got & bits) !== (exp & bits)) begin
         $display("ERROR %s got %h expected %h mask %h", name, got, exp, mask);
         rdata_errs++;
      end
   endtask

   task automatic check_resp(input string name, input bus_resp_e got, input bus_resp_e exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         resp_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         flag_errs++;
      end
   endtask

   ////////////////////////////////////////
   // one bus transaction from falling edge to falling edge

   task automatic run_access(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                             input bus_strb_t wstrb, input int stall, output bus_data_t rdata,
                             output bus_resp_e resp, output logic ok);
      int          waited;
      int          held;
      logic        seen;
      logic [31:0] r;
      ok = 1'b0;
      if (aborted) return;
      req_valid_i = 1'b1;
      req_write_i = wr;
      req_addr_i  = addr;
      req_wdata_i = wdata;
      req_wstrb_i = wstrb;
      waited = 0;
      while (!req_ready_o && waited < WAIT_LIMIT) begin
         @(negedge ram_clk);
         waited++;
      end
      if (!req_ready_o) begin
         $display("timeout: request to %h was never accepted", addr);
         timeout_errs++;
         aborted = 1'b1;
         return;
      end
      @(posedge ram_clk);                 // accepted here
      @(negedge ram_clk);
      req_valid_i = 1'b0;
      waited = 0;
      held   = 0;
      seen   = 1'b0;
      while (!ok && waited < WAIT_LIMIT) begin
         check_flag("req_ready_o", req_ready_o, 1'b0);   // still busy
         r = next_rand();
         if (rsp_valid_o && !seen) begin
            rdata = rsp_rdata_o;
            resp  = rsp_resp_o;
            seen  = 1'b1;
         end else if (rsp_valid_o) begin
            check_rdata("rsp_rdata_o", rsp_rdata_o, rdata, '1);   // held under stall
            check_resp("rsp_resp_o", rsp_resp_o, resp);
         end
         rsp_ready_i = r[0] && (!rsp_valid_o || held >= stall);
         if (rsp_valid_o) held++;
         if (rsp_valid_o && rsp_ready_i) begin
            @(posedge ram_clk);
            ok = 1'b1;
         end
         @(negedge ram_clk);
         waited++;
      end
      rsp_ready_i = 1'b0;
      if (!ok) begin
         $display("timeout: no response for request to %h", addr);
         timeout_errs++;
         aborted = 1'b1;
         return;
      end
      check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
      check_flag("req_ready_o", req_ready_o, 1'b1);
   endtask

   ////////////////////////////////////////
   // model side

   task automatic model_lookup(input bus_addr_t a, output int dev, output int off);
      dev = -1;
      off = 0;
      if (a >= BOOT_BASE && a < BOOT_BASE + (32'd1 << BOOT_MEM_BITS)) begin
         dev = 0;
         off = int'(a - BOOT_BASE);
      end else if (a >= VIDEO_BASE && a < VIDEO_BASE + (32'd1 << VIDEO_MEM_BITS)) begin
         dev = 1;
         off = int'(a - VIDEO_BASE);
      end
   endtask

   task automatic issue_and_check(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                                  input bus_strb_t wstrb, input int stall);
      bus_data_t got_data, exp_data;
      bus_resp_e got_resp, exp_resp;
      bus_strb_t mask;
      logic      ok;
      int        dev, off;
      run_access(wr, addr, wdata, wstrb, stall, got_data, got_resp, ok);
      if (!ok) return;
      model_lookup(addr, dev, off);
      exp_data = '0;
      mask     = '1;
      exp_resp = (dev < 0) ? RESP_DECERR : RESP_OKAY;
      for (int b = 0; b < BUS_STRB_W && dev >= 0; b++) begin
         if (wr && wstrb[b]) begin
            model_mem[dev][off+b] = wdata[b*8 +: 8];
            model_wr[dev][off+b]  = 1'b1;
         end else if (!wr) begin
            exp_data[b*8 +: 8] = model_mem[dev][off+b];
            mask[b]            = model_wr[dev][off+b];   // unwritten bytes are undefined
         end
      end
      check_resp("rsp_resp_o", got_resp, exp_resp);
      check_rdata("rsp_rdata_o", got_data, exp_data, mask);
   endtask

   function automatic bus_addr_t random_addr(input logic [31:0] r);
      bus_addr_t idx_off;
      int        size;
      idx_off = bus_addr_t'(r[8:4]) << 3;
      size    = r[2] ? (1 << VIDEO_MEM_BITS) : (1 << BOOT_MEM_BITS);
      if (r[2:0] == 3'd0) begin
         case (r[12:11])   // just past each memory, below the map, far above
            2'd0:    return 32'h4001_0000 + idx_off;
            2'd1:    return 32'h4014_0000 + idx_off;
            2'd2:    return 32'h3fff_ff00 + idx_off;
            default: return 32'h8000_0000 + idx_off;
         endcase
      end
      if (r[9]) idx_off = idx_off + bus_addr_t'(size - 256);   // top of the memory
      return (r[2] ? VIDEO_BASE : BOOT_BASE) + idx_off;
   endfunction

   ////////////////////////////////////////
   // main sequence

   initial begin : main
      logic [31:0] r;
      int          waited;
      req_valid_i = 1'b0;
      req_write_i = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_wstrb_i = '0;
      rsp_ready_i = 1'b0;
      rng_state   = 32'h1844_c5b0;
      aborted     = 1'b0;
      waited      = 0;
      while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
         @(negedge ram_clk);
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("timeout: reset was never released");
         timeout_errs++;
         aborted = 1'b1;
      end else begin
         @(negedge ram_clk);
         check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
         check_flag("req_ready_o", req_ready_o, 1'b1);
      end
      issue_and_check(1'b1, BOOT_BASE, 64'h0123_4567_89ab_cdef, '1, 0);
      issue_and_check(1'b0, BOOT_BASE, '0, '0, 0);
      // both words of one line, then a partial merge
      issue_and_check(1'b1, BOOT_BASE + 32'h20, 64'h1111_2222_3333_4444, '1, 0);
      issue_and_check(1'b1, BOOT_BASE + 32'h28, 64'h5555_6666_7777_8888, '1, 0);
      issue_and_check(1'b1, BOOT_BASE + 32'h20, 64'haaaa_bbbb_cccc_dddd, 8'h5a, 0);
      issue_and_check(1'b0, BOOT_BASE + 32'h20, '0, '0, 0);
      issue_and_check(1'b0, BOOT_BASE + 32'h28, '0, '0, 0);
      issue_and_check(1'b1, VIDEO_BASE + 32'h100, 64'hfeed_face_cafe_beef, '1, 0);
      issue_and_check(1'b1, BOOT_BASE + 32'h100, 64'h0bad_f00d_dead_c0de, '1, 0);
      issue_and_check(1'b0, VIDEO_BASE + 32'h100, '0, '0, 0);
      issue_and_check(1'b0, BOOT_BASE + 32'h100, '0, '0, 0);
      // aliases of offset 0 if decoded wrongly
      issue_and_check(1'b1, VIDEO_BASE, 64'h3c3c_3c3c_a5a5_a5a5, '1, 0);
      issue_and_check(1'b1, 32'h4001_0000, 64'h9999_9999_9999_9999, '1, 0);
      issue_and_check(1'b1, 32'h4014_0000, 64'h7777_7777_7777_7777, '1, 0);
      issue_and_check(1'b0, 32'h4001_0000, '0, '0, 0);
      issue_and_check(1'b0, BOOT_BASE, '0, '0, 0);
      issue_and_check(1'b0, VIDEO_BASE, '0, '0, 0);
      issue_and_check(1'b0, BOOT_BASE + 32'h20, '0, '0, 6);   // long stall
      for (int n = 0; n < NUM_RANDOM; n++) begin
         r = next_rand();
         issue_and_check(r[10], random_addr(r), {next_rand(), next_rand()},
                         bus_strb_t'(r[31:24]), int'(r[14:13]));
      end
      $display("errors: rdata %0d, resp %0d, flag %0d, timeout %0d",
               rdata_errs, resp_errs, flag_errs, timeout_errs);
      if (rdata_errs + resp_errs + flag_errs + timeout_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
bus_pkg.sv
io_map_pkg.sv
lite_if.sv
io_addr_decode.sv
lite_bram_ctrl.sv
bram_lane_mem.sv
io_subsys_top.sv
tb_clk_gen.sv
tb_io_subsys.sv

// ==== Bender.yml ====
package:
  name: io_subsys

sources:
  - bus_pkg.sv
  - io_map_pkg.sv
  - lite_if.sv
  - io_addr_decode.sv
  - lite_bram_ctrl.sv
  - bram_lane_mem.sv
  - io_subsys_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_io_subsys.sv
